// ==== verilog/uartRx_macros.svh ====
`ifndef UART_RX_MACROS_SVH
`define UART_RX_MACROS_SVH

// ticks per bit period
`define OVERSAMPLE 20

// start edge to start-bit center
`define HALF_BIT 10

// data bits per frame, sent LSB first
`define DATA_BITS 8

// length of the free-running divider
`define DIV_STAGES 13

// rate code width, codes above DIV_STAGES-1 clamp
`define SEL_WIDTH 4

`endif

// ==== verilog/baudPkg.sv ====
`include "uartRx_macros.svh"

package baudPkg;

  // rate code k gives one tick every 2^(k+1) clocks
  typedef logic [`SEL_WIDTH-1:0] baudSel_t;

  // free-running divider value
  typedef logic [`DIV_STAGES-1:0] divCount_t;

endpackage

// ==== verilog/uartRxPkg.sv ====
`include "uartRx_macros.svh"

package uartRxPkg;

  typedef logic [`DATA_BITS-1:0] rxByte_t;

  // parity handling opcode
  typedef enum logic [1:0] {
    PARITY_NONE,
    PARITY_EVEN,
    PARITY_ODD
  } parityMode_t;

  typedef enum logic [2:0] {
    RX_IDLE,   // waiting for a falling edge
    RX_START,  // timing to the start-bit center
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rxState_t;

  // oversample ticks within one bit
  typedef logic [$clog2(`OVERSAMPLE)-1:0] tickCount_t;

  // index of the data bit being sampled
  typedef logic [$clog2(`DATA_BITS)-1:0] bitCount_t;

endpackage

// ==== verilog/baudTickGen.sv ====
`include "uartRx_macros.svh"

module baudTickGen (
  input  logic              clk,
  input  logic              reset,
  input  baudPkg::baudSel_t baudSel,
  output logic              sampleTick
);

  import baudPkg::*;

  divCount_t divCount;    // free-running divider
  baudSel_t  clampedSel;  // codes 13..15 act as 12
  divCount_t tickMask;    // low k+1 bits set
  logic      tickHit;

  always_comb
  begin
    if (baudSel > baudSel_t'(`DIV_STAGES - 1))
      clampedSel = baudSel_t'(`DIV_STAGES - 1);
    else
      clampedSel = baudSel;
  end

  // one bit of mask per divider stage in use
  assign tickMask = {`DIV_STAGES{1'b1}} >> (`DIV_STAGES - 1 - clampedSel);

  assign tickHit = ((divCount & tickMask) == tickMask);  // prefix all ones

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      divCount <= '0;
    end
    else
    begin
      divCount <= divCount + 1'b1;
    end
  end

  // registered so the enable is a clean single-cycle pulse
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sampleTick <= 1'b0;
    end
    else
    begin
      sampleTick <= tickHit;
    end
  end

endmodule

// ==== verilog/rxFrameReceiver.sv ====
`include "uartRx_macros.svh"

module rxFrameReceiver (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   rx,
  input  logic                   sampleTick,
  input  uartRxPkg::parityMode_t parityMode,
  output logic                   byteDone,
  output uartRxPkg::rxByte_t     byteData,
  output logic                   byteParityBit,
  output logic                   byteParityError,
  output logic                   byteFrameError
);

  import uartRxPkg::*;

  logic       rxMeta;     // first sync stage
  logic       rxSync;     // line as seen by the FSM
  logic       rxPrev;     // for edge detection
  logic       startEdge;
  logic       halfTick;   // start-bit center reached
  logic       bitTick;    // center of a later bit
  logic       dataXor;
  rxState_t   state;
  tickCount_t tickCount;
  bitCount_t  bitCount;
  rxByte_t    shiftReg;
  logic       parityBit;

  // line idles high, so the sync chain resets to 1
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
      rxPrev <= 1'b1;
    end
    else
    begin
      rxMeta <= rx;
      rxSync <= rxMeta;
      rxPrev <= rxSync;
    end
  end

  assign startEdge = rxPrev & ~rxSync;  // falling edge
  assign halfTick  = sampleTick && (tickCount == tickCount_t'(`HALF_BIT - 1));
  assign bitTick   = sampleTick && (tickCount == tickCount_t'(`OVERSAMPLE - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= RX_IDLE;
      tickCount <= '0;
      bitCount  <= '0;
    end
    else
    begin
      case (state)
        RX_IDLE:
        begin
          if (startEdge)
          begin
            state     <= RX_START;
            tickCount <= '0;
          end
        end
        RX_START:
        begin
          if (halfTick)
          begin
            tickCount <= '0;
            bitCount  <= '0;
            state     <= rxSync ? RX_IDLE : RX_DATA;  // high here means a glitch
          end
          else if (sampleTick)
            tickCount <= tickCount + 1'b1;
        end
        RX_DATA:
        begin
          if (bitTick)
          begin
            tickCount <= '0;
            if (bitCount == bitCount_t'(`DATA_BITS - 1))
              state <= (parityMode == PARITY_NONE) ? RX_STOP : RX_PARITY;
            else
              bitCount <= bitCount + 1'b1;
          end
          else if (sampleTick)
            tickCount <= tickCount + 1'b1;
        end
        RX_PARITY:
        begin
          if (bitTick)
          begin
            tickCount <= '0;
            state     <= RX_STOP;
          end
          else if (sampleTick)
            tickCount <= tickCount + 1'b1;
        end
        RX_STOP:
        begin
          if (bitTick)
            state <= RX_IDLE;  // same cycle as byteDone
          else if (sampleTick)
            tickCount <= tickCount + 1'b1;
        end
        default:
          state <= RX_IDLE;
      endcase
    end
  end

  // data bits shift in from the top, LSB first
  always_ff @(posedge clk)
  begin
    if (state == RX_DATA && bitTick)
      shiftReg <= {rxSync, shiftReg[`DATA_BITS-1:1]};
    if (state == RX_PARITY && bitTick)
      parityBit <= rxSync;
  end

  assign byteDone       = (state == RX_STOP) && bitTick;
  assign byteData       = shiftReg;
  assign byteFrameError = ~rxSync;  // stop sample taken this cycle
  assign dataXor        = ^{shiftReg, parityBit};

  always_comb
  begin
    case (parityMode)
      PARITY_EVEN:
      begin
        byteParityBit   = parityBit;
        byteParityError = dataXor;
      end
      PARITY_ODD:
      begin
        byteParityBit   = parityBit;
        byteParityError = ~dataXor;
      end
      default:
      begin
        byteParityBit   = 1'b0;  // no parity bit on the line
        byteParityError = 1'b0;
      end
    endcase
  end

endmodule

// ==== verilog/rxHoldRegister.sv ====
module rxHoldRegister (
  input  logic               clk,
  input  logic               reset,
  input  logic               byteDone,
  input  uartRxPkg::rxByte_t byteData,
  input  logic               byteParityBit,
  input  logic               byteParityError,
  input  logic               byteFrameError,
  input  logic               rxRead,
  output uartRxPkg::rxByte_t rxData,
  output logic               rxParityBit,
  output logic               parityError,
  output logic               frameError,
  output logic               rxValid,
  output logic               overrun
);

  // payload, loaded on every finished frame
  always_ff @(posedge clk)
  begin
    if (byteDone)
    begin
      rxData      <= byteData;
      rxParityBit <= byteParityBit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rxValid     <= 1'b0;
      overrun     <= 1'b0;
      parityError <= 1'b0;
      frameError  <= 1'b0;
    end
    else
    begin
      if (byteDone)
      begin
        parityError <= byteParityError;  // status follows the held byte
        frameError  <= byteFrameError;
      end

      // a new byte wins over a read in the same cycle
      if (byteDone)
        rxValid <= 1'b1;
      else if (rxRead)
        rxValid <= 1'b0;

      if (rxRead)
        overrun <= 1'b0;
      else if (byteDone && rxValid)
        overrun <= 1'b1;  // unread byte overwritten
    end
  end

endmodule

// ==== verilog/uartRx.sv ====
module uartRx (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   rx,
  input  baudPkg::baudSel_t      baudSel,
  input  uartRxPkg::parityMode_t parityMode,
  input  logic                   rxRead,
  output uartRxPkg::rxByte_t     rxData,
  output logic                   rxParityBit,
  output logic                   rxValid,
  output logic                   parityError,
  output logic                   frameError,
  output logic                   overrun
);

  import uartRxPkg::*;

  logic    sampleTick;     // oversample enable
  logic    byteDone;
  rxByte_t byteData;
  logic    byteParityBit;
  logic    byteParityError;
  logic    byteFrameError;

  baudTickGen tickGen0 (
    .clk        (clk),
    .reset      (reset),
    .baudSel    (baudSel),
    .sampleTick (sampleTick)
  );

  rxFrameReceiver frameRx0 (
    .clk             (clk),
    .reset           (reset),
    .rx              (rx),
    .sampleTick      (sampleTick),
    .parityMode      (parityMode),
    .byteDone        (byteDone),
    .byteData        (byteData),
    .byteParityBit   (byteParityBit),
    .byteParityError (byteParityError),
    .byteFrameError  (byteFrameError)
  );

  rxHoldRegister holdReg0 (
    .clk             (clk),
    .reset           (reset),
    .byteDone        (byteDone),
    .byteData        (byteData),
    .byteParityBit   (byteParityBit),
    .byteParityError (byteParityError),
    .byteFrameError  (byteFrameError),
    .rxRead          (rxRead),
    .rxData          (rxData),
    .rxParityBit     (rxParityBit),
    .parityError     (parityError),
    .frameError      (frameError),
    .rxValid         (rxValid),
    .overrun         (overrun)
  );

endmodule

// ==== test/uartRxTb.sv ====
`include "uartRx_macros.svh"

module uartRxTb;

  import baudPkg::*;
  import uartRxPkg::*;

  localparam int FRAME_BITS = 14;  // start, data, parity, stop, up to 3 idle bits

  typedef struct packed {
    rxByte_t data;
    logic    parityBit;
    logic    parityError;
    logic    frameError;
    logic    overrun;
  } expect_t;

  logic        clk;
  logic        reset;
  logic        rx;
  baudSel_t    baudSel;
  parityMode_t parityMode;
  logic        rxRead;
  rxByte_t     rxData;
  logic        rxParityBit;
  logic        rxValid;
  logic        parityError;
  logic        frameError;
  logic        overrun;

  expect_t     expectQ[$];  // frames on the line, oldest first
  string       testName;
  logic        holdReads;   // host stops reading
  logic        readBusy;    // compare process mid-read
  int          errorCount;
  int          checkCount;
  logic [31:0] rngState;

  uartRx dut0 (
    .clk         (clk),
    .reset       (reset),
    .rx          (rx),
    .baudSel     (baudSel),
    .parityMode  (parityMode),
    .rxRead      (rxRead),
    .rxData      (rxData),
    .rxParityBit (rxParityBit),
    .rxValid     (rxValid),
    .parityError (parityError),
    .frameError  (frameError),
    .overrun     (overrun)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // clocks per bit for rate code k
  function automatic int bitClocks(int code);
    return `OVERSAMPLE * (2 << code);
  endfunction

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // parity bit the sender puts on the line, flip corrupts it
  function automatic logic sentParity(rxByte_t data, parityMode_t mode, logic flip);
    return (^data) ^ (mode == PARITY_ODD) ^ flip;
  endfunction

  function automatic expect_t frameExpect(rxByte_t data, parityMode_t mode, logic flip,
                                          logic stopBit);
    expect_t e;
    logic    pbit;
    pbit         = sentParity(data, mode, flip);
    e.data       = data;
    e.overrun    = 1'b0;
    e.frameError = ~stopBit;  // stop sampled low
    case (mode)
      PARITY_EVEN, PARITY_ODD:
      begin
        e.parityBit   = pbit;
        e.parityError = flip;  // only a corrupted bit breaks parity
      end
      default:
      begin
        e.parityBit   = 1'b0;
        e.parityError = 1'b0;
      end
    endcase
    return e;
  endfunction

  task automatic checkByte(string what, rxByte_t expected, rxByte_t actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("FAILED %s %s: expected %h, got %h", testName, what, expected, actual);
    end
  endtask

  task automatic checkFlag(string what, logic expected, logic actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("FAILED %s %s: expected %b, got %b", testName, what, expected, actual);
    end
  endtask

  // called at edge+1, returns at edge+1
  task automatic holdLine(logic level, int cycles);
    rx = level;
    repeat (cycles) @(posedge clk);
    #1;
  endtask

  task automatic sendFrame(rxByte_t data, logic flip, logic stopBit, int code, int gapBits);
    int bc;
    int i;
    bc = bitClocks(code);
    holdLine(1'b0, bc);  // start bit
    for (i = 0; i < `DATA_BITS; i++)
      holdLine(data[i], bc);
    if (parityMode != PARITY_NONE)
      holdLine(sentParity(data, parityMode, flip), bc);
    holdLine(stopBit, bc);
    holdLine(1'b1, gapBits * bc);  // idle between frames
  endtask

  task automatic waitDrained(int code);
    int       waited;
    int       limit;
    rxState_t st;
    waited = 0;
    limit  = 2 * bitClocks(code);
    while ((expectQ.size() != 0 || readBusy) && waited < limit)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (expectQ.size() != 0)
    begin
      st = dut0.frameRx0.state;
      errorCount++;
      $display("%s: no rxValid within %0d cycles, receiver in %s", testName, limit, st.name());
      expectQ.delete();
    end
  endtask

  task automatic runFrame(rxByte_t data, logic flip, logic stopBit, int code);
    int gapBits;
    rngState = xorshift(rngState);
    gapBits  = 1 + int'(rngState % 3);
    expectQ.push_back(frameExpect(data, parityMode, flip, stopBit));
    sendFrame(data, flip, stopBit, code, gapBits);
    waitDrained(code);
  endtask

  task automatic configure(string name, int code, parityMode_t mode);
    testName   = name;
    baudSel    = baudSel_t'(code);
    parityMode = mode;
  endtask

  // reads each byte as soon as rxValid is seen
  initial
  begin : compareProc
    expect_t e;
    forever
    begin
      @(posedge clk);
      #1;
      if (rxValid === 1'b1 && !holdReads)
      begin
        readBusy = 1'b1;
        if (expectQ.size() == 0)
        begin
          errorCount++;
          $display("%s: rxValid rose with no frame sent on the line", testName);
        end
        else
        begin
          e = expectQ.pop_front();
          checkByte("rxData", e.data, rxData);
          checkFlag("rxParityBit", e.parityBit, rxParityBit);
          checkFlag("parityError", e.parityError, parityError);
          checkFlag("frameError", e.frameError, frameError);
          checkFlag("overrun", e.overrun, overrun);
        end
        rxRead = 1'b1;
        @(posedge clk);
        #1;
        rxRead   = 1'b0;
        readBusy = 1'b0;
      end
    end
  end

  // budget counts frames per rate: 22 at code 0, 8 at code 2, 4 at code 1, 1 at code 12
  initial
  begin : watchdog
    int limit;
    limit = 2 * FRAME_BITS * (22 * bitClocks(0) + 8 * bitClocks(2) + 4 * bitClocks(1)
            + bitClocks(12)) + 2000;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles in %s", limit, testName);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin : mainProc
    expect_t e;
    int      i;
    reset      = 1'b1;
    rx         = 1'b1;
    baudSel    = '0;
    parityMode = PARITY_NONE;
    rxRead     = 1'b0;
    holdReads  = 1'b0;
    readBusy   = 1'b0;
    errorCount = 0;
    checkCount = 0;
    testName   = "reset";
    rngState   = 32'h3da6_4691;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (4) @(posedge clk);
    #1;

    configure("randomNoneRate0", 0, PARITY_NONE);
    for (i = 0; i < 8; i++)
    begin
      rngState = xorshift(rngState);
      runFrame(rngState[7:0], 1'b0, 1'b1, 0);
    end
    configure("randomNoneRate2", 2, PARITY_NONE);
    for (i = 0; i < 8; i++)
    begin
      rngState = xorshift(rngState);
      runFrame(rngState[7:0], 1'b0, 1'b1, 2);
    end

    configure("parityEven", 0, PARITY_EVEN);
    for (i = 0; i < 6; i++)
    begin
      rngState = xorshift(rngState);
      runFrame(rngState[7:0], (i % 3 == 2), 1'b1, 0);  // every third parity flipped
    end
    configure("parityOdd", 0, PARITY_ODD);
    for (i = 0; i < 6; i++)
    begin
      rngState = xorshift(rngState);
      runFrame(rngState[7:0], (i % 3 == 2), 1'b1, 0);
    end

    configure("frameError", 1, PARITY_NONE);
    runFrame(8'h3c, 1'b0, 1'b0, 1);  // stop bit held low
    runFrame(8'hc3, 1'b0, 1'b1, 1);

    configure("glitch", 1, PARITY_NONE);
    holdLine(1'b0, bitClocks(1) / 4 - 14);  // well under a quarter bit
    holdLine(1'b1, 2 * bitClocks(1));
    runFrame(8'h96, 1'b0, 1'b1, 1);

    configure("overrun", 0, PARITY_NONE);
    holdReads = 1'b1;
    sendFrame(8'h11, 1'b0, 1'b1, 0, 1);
    e         = frameExpect(8'h22, PARITY_NONE, 1'b0, 1'b1);
    e.overrun = 1'b1;  // first byte lost
    expectQ.push_back(e);
    sendFrame(8'h22, 1'b0, 1'b1, 0, 1);
    holdReads = 1'b0;
    waitDrained(0);
    checkFlag("rxValid after read", 1'b0, rxValid);
    checkFlag("overrun after read", 1'b0, overrun);

    // code 15 clamps to the code 12 rate
    configure("rate15", 15, PARITY_NONE);
    runFrame(8'h5a, 1'b0, 1'b1, 12);

    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== uartRx.f ====
+incdir+verilog
verilog/baudPkg.sv
verilog/uartRxPkg.sv
verilog/baudTickGen.sv
verilog/rxFrameReceiver.sv
verilog/rxHoldRegister.sv
verilog/uartRx.sv
test/uartRxTb.sv

// ==== Bender.yml ====
package:
  name: uartRx

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/baudPkg.sv
      - verilog/uartRxPkg.sv
      - verilog/baudTickGen.sv
      - verilog/rxFrameReceiver.sv
      - verilog/rxHoldRegister.sv
      - verilog/uartRx.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/uartRxTb.sv
